//--- Makefile
SIM  := obj_dir/Vtb_fixed_weight
SRCS := $(shell cat fixed_weight_top.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): fixed_weight_top.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_fixed_weight \
		-f fixed_weight_top.f -o Vtb_fixed_weight

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

//--- design/error_vector_builder.sv
`timescale 1ns/1ps

module error_vector_builder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start_build,
    output fixed_weight_pkg::loc_req_t   loc_req,
    input  fixed_weight_pkg::loc_t       loc_data,
    input  fixed_weight_pkg::rd_req_t    rd_req,
    output fixed_weight_pkg::word_t      rd_data,
    output logic                         build_done,
    output logic                         collision
);

    typedef enum logic [1:0] {
        ph_idle,
        ph_clear,
        ph_read,
        ph_write
    } build_phase_t;

    build_phase_t                phase;
    fixed_weight_pkg::vec_addr_t clr_cnt;
    fixed_weight_pkg::vec_addr_t ram_addr;
    fixed_weight_pkg::vec_addr_t rd_addr_q;
    logic [5:0]                  loc_idx;
    fixed_weight_pkg::loc_t      cur_loc;
    fixed_weight_pkg::word_t     ram_rdata;
    fixed_weight_pkg::word_t     ram_wdata;
    logic                        ram_we;
    logic                        bit_set;

    // look one location ahead during the write cycle
    assign loc_req.en  = (phase != ph_idle);
    assign loc_req.idx = (phase == ph_write) ? loc_idx + 6'd1 : loc_idx;

    assign bit_set = ram_rdata[cur_loc[4:0]];
    assign rd_data = ram_rdata;

    always_comb begin
        ram_we    = 1'b0;
        ram_wdata = ram_rdata | (32'd1 << cur_loc[4:0]);
        ram_addr  = rd_req.en ? rd_req.addr : rd_addr_q;
        case (phase)
            ph_clear: begin
                ram_we    = 1'b1;
                ram_wdata = '0;
                ram_addr  = clr_cnt;
            end
            ph_read: begin
                ram_addr = loc_data[fixed_weight_pkg::loc_width-1:5];
            end
            ph_write: begin
                ram_we   = !bit_set;
                ram_addr = cur_loc[fixed_weight_pkg::loc_width-1:5];
            end
            default: begin
            end
        endcase
    end

    word_ram #(
        .data_width(32),
        .depth(fixed_weight_pkg::vec_words)
    ) u_vec_ram (
        .clk(clk),
        .we(ram_we),
        .addr(ram_addr),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

    always_ff @(posedge clk) begin
        if (phase == ph_read) begin
            cur_loc <= loc_data;
        end
        if (rd_req.en) begin
            rd_addr_q <= rd_req.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= ph_idle;
            clr_cnt    <= '0;
            loc_idx    <= '0;
            build_done <= 1'b0;
            collision  <= 1'b0;
        end else begin
            build_done <= 1'b0;
            collision  <= 1'b0;
            case (phase)
                ph_idle: begin
                    if (start_build) begin
                        phase   <= ph_clear;
                        clr_cnt <= '0;
                        loc_idx <= '0;
                    end
                end
                ph_clear: begin
                    clr_cnt <= clr_cnt + 7'd1;
                    if (clr_cnt == 7'(fixed_weight_pkg::vec_words - 1)) begin
                        phase <= ph_read;
                    end
                end
                ph_read: begin
                    phase <= ph_write;
                end
                ph_write: begin
                    if (bit_set) begin
                        // repeated location, attempt is void
                        collision <= 1'b1;
                        phase     <= ph_idle;
                    end else if (loc_idx == 6'(fixed_weight_pkg::weight - 1)) begin
                        build_done <= 1'b1;
                        phase      <= ph_idle;
                    end else begin
                        loc_idx <= loc_idx + 6'd1;
                        phase   <= ph_read;
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

endmodule

//--- design/fixed_weight_ctrl.sv
`timescale 1ns/1ps

module fixed_weight_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic seed_full,
    input  logic absorb_done,
    input  logic sample_done,
    input  logic weight_ok,
    input  logic build_done,
    input  logic collision,
    input  logic seed_accept,
    output logic start_absorb,
    output logic start_sample,
    output logic start_build,
    output logic done,
    output logic vector_valid
);

    fixed_weight_pkg::ctrl_state_t state;

    // seed stays claimed from absorb through build
    assign start_absorb = (state == fixed_weight_pkg::st_absorb) ||
                          (state == fixed_weight_pkg::st_sample) ||
                          (state == fixed_weight_pkg::st_build);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= fixed_weight_pkg::st_idle;
            start_sample <= 1'b0;
            start_build  <= 1'b0;
            done         <= 1'b0;
            vector_valid <= 1'b0;
        end else begin
            start_sample <= 1'b0;
            start_build  <= 1'b0;
            done         <= 1'b0;
            if (seed_accept) begin
                vector_valid <= 1'b0;
            end
            case (state)
                fixed_weight_pkg::st_idle, fixed_weight_pkg::st_ready: begin
                    // a full buffer only counts once the old vector was released
                    if (seed_full && !vector_valid) begin
                        state <= fixed_weight_pkg::st_absorb;
                    end
                end
                fixed_weight_pkg::st_absorb: begin
                    if (absorb_done) begin
                        state        <= fixed_weight_pkg::st_sample;
                        start_sample <= 1'b1;
                    end
                end
                fixed_weight_pkg::st_sample: begin
                    if (sample_done) begin
                        if (weight_ok) begin
                            state       <= fixed_weight_pkg::st_build;
                            start_build <= 1'b1;
                        end else begin
                            // short weight, squeeze another attempt
                            start_sample <= 1'b1;
                        end
                    end
                end
                fixed_weight_pkg::st_build: begin
                    if (build_done) begin
                        state        <= fixed_weight_pkg::st_ready;
                        done         <= 1'b1;
                        vector_valid <= 1'b1;
                    end else if (collision) begin
                        state        <= fixed_weight_pkg::st_sample;
                        start_sample <= 1'b1;
                    end
                end
                default: state <= fixed_weight_pkg::st_idle;
            endcase
        end
    end

endmodule

//--- design/fixed_weight_pkg.sv
package fixed_weight_pkg;

    // code parameters for n = 3488, m = 12, t = 64
    localparam int vec_len   = 3488;
    localparam int loc_width = 12;
    localparam int weight    = 64;
    // tau is 2t because n is below 2^m
    localparam int n_samples = 2 * weight;

    // 512-bit seed, two 16-bit samples per squeezed word
    localparam int seed_words    = 16;
    localparam int squeeze_words = n_samples / 2;

    // vector length rounded up to whole 32-bit words
    localparam int vec_words = (vec_len + 31) / 32;

    typedef logic [31:0] word_t;
    typedef logic [loc_width-1:0] loc_t;
    typedef logic [6:0] vec_addr_t;

    // absorb header, output length first, then input length
    localparam word_t xof_out_len_word = 32'h40000a00;
    localparam word_t xof_in_len_word  = 32'h80000200;

    typedef struct packed {
        logic  valid;
        word_t data;
    } word_stream_t;

    typedef struct packed {
        logic      en;
        vec_addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic       en;
        logic [5:0] idx;
    } loc_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_absorb,
        st_sample,
        st_build,
        st_ready
    } ctrl_state_t;

endpackage

//--- design/fixed_weight_top.sv
`timescale 1ns/1ps

module fixed_weight_top (
    input  logic                           clk,
    input  logic                           rst,
    input  fixed_weight_pkg::word_stream_t seed_in,
    output logic                           seed_ready,
    output fixed_weight_pkg::word_stream_t absorb,
    input  logic                           absorb_ready,
    input  fixed_weight_pkg::word_stream_t squeeze,
    output logic                           squeeze_ready,
    input  fixed_weight_pkg::rd_req_t      rd_req,
    output fixed_weight_pkg::word_t        rd_data,
    output logic                           done,
    output logic                           vector_valid
);

    logic                       seed_accept;
    logic                       seed_full;
    logic                       start_absorb;
    logic                       absorb_done;
    logic                       start_sample;
    logic                       sample_done;
    logic                       weight_ok;
    logic                       start_build;
    logic                       build_done;
    logic                       collision;
    fixed_weight_pkg::loc_req_t loc_req;
    fixed_weight_pkg::loc_t     loc_data;

    // a new seed word marks the old vector as stale
    assign seed_accept = seed_in.valid && seed_ready;

    seed_loader u_seed_loader (
        .clk(clk),
        .rst(rst),
        .seed_in(seed_in),
        .seed_ready(seed_ready),
        .start_absorb(start_absorb),
        .absorb(absorb),
        .absorb_ready(absorb_ready),
        .absorb_done(absorb_done),
        .seed_full(seed_full)
    );

    location_sampler u_sampler (
        .clk(clk),
        .rst(rst),
        .start_sample(start_sample),
        .squeeze(squeeze),
        .squeeze_ready(squeeze_ready),
        .loc_req(loc_req),
        .loc_data(loc_data),
        .sample_done(sample_done),
        .weight_ok(weight_ok)
    );

    error_vector_builder u_builder (
        .clk(clk),
        .rst(rst),
        .start_build(start_build),
        .loc_req(loc_req),
        .loc_data(loc_data),
        .rd_req(rd_req),
        .rd_data(rd_data),
        .build_done(build_done),
        .collision(collision)
    );

    fixed_weight_ctrl u_ctrl (
        .clk(clk),
        .rst(rst),
        .seed_full(seed_full),
        .absorb_done(absorb_done),
        .sample_done(sample_done),
        .weight_ok(weight_ok),
        .build_done(build_done),
        .collision(collision),
        .seed_accept(seed_accept),
        .start_absorb(start_absorb),
        .start_sample(start_sample),
        .start_build(start_build),
        .done(done),
        .vector_valid(vector_valid)
    );

endmodule

//--- design/location_sampler.sv
`timescale 1ns/1ps

module location_sampler (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start_sample,
    input  fixed_weight_pkg::word_stream_t squeeze,
    output logic                           squeeze_ready,
    input  fixed_weight_pkg::loc_req_t     loc_req,
    output fixed_weight_pkg::loc_t         loc_data,
    output logic                           sample_done,
    output logic                           weight_ok
);

    logic                   active;
    logic                   second_half;
    logic [6:0]             word_cnt;
    logic [6:0]             loc_cnt;
    logic [31:0]            swapped;
    fixed_weight_pkg::loc_t lo_cand;
    fixed_weight_pkg::loc_t cand;
    logic                   take;
    logic                   cand_ok;
    logic                   store;
    logic [5:0]             ram_addr;

    // bit-reverse a 16-bit sample and keep the low m bits
    function automatic fixed_weight_pkg::loc_t decode_half(input logic [15:0] half);
        logic [15:0] rev;
        for (int i = 0; i < 16; i++) begin
            rev[i] = half[15 - i];
        end
        return rev[fixed_weight_pkg::loc_width-1:0];
    endfunction

    // XOF words arrive little-endian
    assign swapped = {squeeze.data[7:0], squeeze.data[15:8],
                      squeeze.data[23:16], squeeze.data[31:24]};

    assign squeeze_ready = active && !second_half;
    assign take          = squeeze.valid && squeeze_ready;

    // upper half straight from the bus, lower half one cycle later from the register
    assign cand    = second_half ? lo_cand : decode_half(swapped[31:16]);
    assign cand_ok = (cand < fixed_weight_pkg::loc_t'(fixed_weight_pkg::vec_len));
    assign store   = (take || second_half) && cand_ok &&
                     (loc_cnt < 7'(fixed_weight_pkg::weight));

    // the builder only reads once sampling is over
    assign ram_addr  = loc_req.en ? loc_req.idx : loc_cnt[5:0];
    assign weight_ok = (loc_cnt == 7'(fixed_weight_pkg::weight));

    word_ram #(
        .data_width(fixed_weight_pkg::loc_width),
        .depth(fixed_weight_pkg::weight)
    ) u_loc_ram (
        .clk(clk),
        .we(store),
        .addr(ram_addr),
        .wdata(cand),
        .rdata(loc_data)
    );

    always_ff @(posedge clk) begin
        if (take) begin
            lo_cand <= decode_half(swapped[15:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active      <= 1'b0;
            second_half <= 1'b0;
            word_cnt    <= '0;
            loc_cnt     <= '0;
            sample_done <= 1'b0;
        end else begin
            sample_done <= 1'b0;
            if (start_sample) begin
                active      <= 1'b1;
                second_half <= 1'b0;
                word_cnt    <= '0;
                loc_cnt     <= '0;
            end else begin
                if (store) begin
                    loc_cnt <= loc_cnt + 7'd1;
                end
                if (take) begin
                    second_half <= 1'b1;
                    word_cnt    <= word_cnt + 7'd1;
                end else if (second_half) begin
                    second_half <= 1'b0;
                    // attempt ends once the last word's lower half is handled
                    if (word_cnt == 7'(fixed_weight_pkg::squeeze_words)) begin
                        active      <= 1'b0;
                        sample_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- design/seed_loader.sv
`timescale 1ns/1ps

module seed_loader (
    input  logic                           clk,
    input  logic                           rst,
    input  fixed_weight_pkg::word_stream_t seed_in,
    output logic                           seed_ready,
    input  logic                           start_absorb,
    output fixed_weight_pkg::word_stream_t absorb,
    input  logic                           absorb_ready,
    output logic                           absorb_done,
    output logic                           seed_full
);

    logic [4:0]              seed_cnt;
    logic                    abs_active;
    logic                    abs_sent;
    logic [4:0]              abs_idx;
    logic [4:0]              abs_idx_next;
    logic                    seed_we;
    logic                    abs_fire;
    logic [3:0]              ram_addr;
    fixed_weight_pkg::word_t ram_rdata;

    assign seed_full    = (seed_cnt == 5'(fixed_weight_pkg::seed_words));
    assign seed_ready   = !seed_full;
    assign seed_we      = seed_in.valid && seed_ready;
    assign abs_fire     = abs_active && absorb_ready;
    assign abs_idx_next = abs_idx + 5'(abs_fire);

    // stream index k >= 2 carries seed word k - 2, so prefetch from the next index
    assign ram_addr = seed_we ? seed_cnt[3:0] : 4'(abs_idx_next - 5'd2);

    word_ram #(
        .data_width(32),
        .depth(fixed_weight_pkg::seed_words)
    ) u_seed_ram (
        .clk(clk),
        .we(seed_we),
        .addr(ram_addr),
        .wdata(seed_in.data),
        .rdata(ram_rdata)
    );

    always_comb begin
        absorb.valid = abs_active;
        case (abs_idx)
            5'd0:    absorb.data = fixed_weight_pkg::xof_out_len_word;
            5'd1:    absorb.data = fixed_weight_pkg::xof_in_len_word;
            default: absorb.data = ram_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            seed_cnt    <= '0;
            abs_active  <= 1'b0;
            abs_sent    <= 1'b0;
            abs_idx     <= '0;
            absorb_done <= 1'b0;
        end else begin
            absorb_done <= 1'b0;
            if (seed_we) begin
                seed_cnt <= seed_cnt + 5'd1;
            end
            if (start_absorb && seed_full && !abs_active && !abs_sent) begin
                abs_active <= 1'b1;
            end else if (abs_fire) begin
                abs_idx <= abs_idx_next;
                // two header words plus the seed
                if (abs_idx == 5'(fixed_weight_pkg::seed_words + 1)) begin
                    abs_idx     <= '0;
                    abs_active  <= 1'b0;
                    abs_sent    <= 1'b1;
                    absorb_done <= 1'b1;
                end
            end
            // controller has let go of the seed, open for the next one
            if (abs_sent && !start_absorb) begin
                seed_cnt <= '0;
                abs_sent <= 1'b0;
            end
        end
    end

endmodule

//--- design/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
    parameter int data_width = 32,
    parameter int depth      = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic [data_width-1:0]    wdata,
    output logic [data_width-1:0]    rdata
);

    logic [data_width-1:0] mem [depth];

    // read returns the old word when the same address is written
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- fixed_weight_top.f
design/fixed_weight_pkg.sv
design/word_ram.sv
design/seed_loader.sv
design/location_sampler.sv
design/error_vector_builder.sv
design/fixed_weight_ctrl.sv
design/fixed_weight_top.sv
sim/tb_clock_gen.sv
sim/fixed_weight_asserts.sv
sim/tb_fixed_weight.sv

//--- sim/fixed_weight_asserts.sv
`timescale 1ns/1ps

module fixed_weight_asserts (
    input logic                           clk,
    input logic                           rst,
    input fixed_weight_pkg::word_stream_t absorb,
    input logic                           absorb_ready,
    input logic                           done,
    input logic                           squeeze_ready,
    input fixed_weight_pkg::ctrl_state_t  state
);

    // absorb word held while the XOF stalls
    absorb_hold: assert property (@(posedge clk) disable iff (rst)
        (absorb.valid && !absorb_ready) |=> $stable(absorb))
        else $error("absorb word changed under back-pressure");

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done held longer than one cycle");

    squeeze_idle: assert property (@(posedge clk) disable iff (rst)
        (state != fixed_weight_pkg::st_sample) |-> !squeeze_ready)
        else $error("squeeze_ready raised outside sampling");

endmodule

bind fixed_weight_top fixed_weight_asserts u_asserts (
    .clk(clk),
    .rst(rst),
    .absorb(absorb),
    .absorb_ready(absorb_ready),
    .done(done),
    .squeeze_ready(squeeze_ready),
    .state(u_ctrl.state)
);

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for 5 cycles, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- sim/tb_fixed_weight.sv
`timescale 1ns/1ps

module tb_fixed_weight;

    localparam int n_seeds     = 4;
    localparam int cycle_limit = n_seeds * 8 * 600;

    logic                           clk;
    logic                           rst;
    fixed_weight_pkg::word_stream_t seed_in;
    fixed_weight_pkg::word_stream_t absorb;
    fixed_weight_pkg::word_stream_t squeeze;
    logic                           seed_ready;
    logic                           absorb_ready;
    logic                           squeeze_ready;
    logic                           done;
    logic                           vector_valid;
    fixed_weight_pkg::rd_req_t      rd_req;
    fixed_weight_pkg::word_t        rd_data;

    fixed_weight_pkg::word_t rng_main;
    fixed_weight_pkg::word_t rng_drv;
    fixed_weight_pkg::word_t absorb_exp [$];
    fixed_weight_pkg::word_t sq_words [$];
    fixed_weight_pkg::word_t sq_cur;
    fixed_weight_pkg::word_t exp_vec [fixed_weight_pkg::vec_words];
    fixed_weight_pkg::word_t rd_vec [fixed_weight_pkg::vec_words];
    logic                    sq_have;
    int                      seed_idx;
    int                      cycle_cnt = 0;

    tb_clock_gen u_clock_gen (
        .clk(clk),
        .rst(rst)
    );

    fixed_weight_top DUT (
        .clk(clk),
        .rst(rst),
        .seed_in(seed_in),
        .seed_ready(seed_ready),
        .absorb(absorb),
        .absorb_ready(absorb_ready),
        .squeeze(squeeze),
        .squeeze_ready(squeeze_ready),
        .rd_req(rd_req),
        .rd_data(rd_data),
        .done(done),
        .vector_valid(vector_valid)
    );

    function automatic fixed_weight_pkg::word_t lcg_next(input fixed_weight_pkg::word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_run(input string what);
        $display(">>> FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_word(input fixed_weight_pkg::word_t got,
                              input fixed_weight_pkg::word_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            fail_run("word mismatch");
        end
    endtask

    task automatic check_loc(input fixed_weight_pkg::loc_t got,
                             input fixed_weight_pkg::loc_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            fail_run("location count mismatch");
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            fail_run("count mismatch");
        end
    endtask

    // reference model of one 64-word attempt into exp_vec
    task automatic model_attempt(input int k, output bit ok);
        fixed_weight_pkg::word_t w;
        fixed_weight_pkg::word_t swapped;
        logic [15:0]             half;
        logic [15:0]             rev;
        fixed_weight_pkg::loc_t  cand;
        logic [4095:0]           seen;
        int                      count;
        ok = 1'b1;
        count = 0;
        seen = '0;
        foreach (exp_vec[i]) exp_vec[i] = '0;
        for (int j = 0; j < fixed_weight_pkg::n_samples; j++) begin
            w = sq_words[k * fixed_weight_pkg::squeeze_words + j / 2];
            swapped = {<<8{w}};
            half = (j % 2 == 0) ? swapped[31:16] : swapped[15:0];
            rev = {<<{half}};
            cand = rev[fixed_weight_pkg::loc_width-1:0];
            if (int'(cand) < fixed_weight_pkg::vec_len && count < fixed_weight_pkg::weight) begin
                if (seen[cand]) begin
                    ok = 1'b0;
                end
                seen[cand] = 1'b1;
                exp_vec[cand[11:5]][cand[4:0]] = 1'b1;
                count++;
            end
        end
        if (count != fixed_weight_pkg::weight) begin
            ok = 1'b0;
        end
    endtask

    task automatic send_seed(input bit expect_clear);
        int                      sent;
        bit                      first_taken;
        fixed_weight_pkg::word_t w;
        sent = 0;
        first_taken = 1'b0;
        rng_main = lcg_next(rng_main);
        w = rng_main;
        while (sent < fixed_weight_pkg::seed_words) begin
            rng_main = lcg_next(rng_main);
            seed_in.valid = rng_main[31] | rng_main[30];
            seed_in.data = w;
            if (seed_in.valid && seed_ready) begin
                absorb_exp.push_back(w);
                sent++;
                first_taken = (sent == 1);
                rng_main = lcg_next(rng_main);
                w = rng_main;
            end
            @(negedge clk);
            if (first_taken && expect_clear && vector_valid) begin
                fail_run("vector_valid still high after a new seed word was accepted");
            end
        end
        seed_in.valid = 1'b0;
    endtask

    // XOF stand-in and absorb checker
    always @(negedge clk) begin
        if (rst) begin
            absorb_ready = 1'b0;
            squeeze.valid = 1'b0;
        end else begin
            rng_drv = lcg_next(rng_drv);
            absorb_ready = rng_drv[31] | rng_drv[30];
            if (absorb.valid && absorb_ready) begin
                if (absorb_exp.size() == 0) begin
                    fail_run("absorb word offered with no seed pending");
                end
                check_word(absorb.data, absorb_exp.pop_front(), "absorb word");
            end
            if (!sq_have) begin
                // seed 0 opens with an all-rejected attempt and seed 1 with a colliding one
                if (seed_idx < 2 && sq_words.size() < fixed_weight_pkg::squeeze_words) begin
                    sq_cur = (seed_idx == 0) ? '1 : '0;
                end else begin
                    sq_cur = lcg_next(rng_drv ^ 32'h9e3779b9);
                end
                sq_have = 1'b1;
            end
            squeeze.valid = rng_drv[29] | rng_drv[28];
            squeeze.data = sq_cur;
            if (squeeze.valid && squeeze_ready) begin
                sq_words.push_back(sq_cur);
                sq_have = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycle_cnt);
            fail_run("timeout");
        end
    end

    initial begin
        bit ok;
        int k;
        int attempts;
        int ones;
        seed_in = '0;
        absorb_ready = 1'b0;
        squeeze = '0;
        rd_req = '0;
        rng_main = 32'h6ce6d669;
        rng_drv = ~rng_main;
        sq_have = 1'b0;
        seed_idx = 0;
        @(negedge clk);
        while (rst) @(negedge clk);
        if (!seed_ready || absorb.valid || squeeze_ready || done || vector_valid) begin
            fail_run("outputs not in their reset state");
        end
        for (int s = 0; s < n_seeds; s++) begin
            seed_idx = s;
            sq_words.delete();
            sq_have = 1'b0;
            absorb_exp.push_back(fixed_weight_pkg::xof_out_len_word);
            absorb_exp.push_back(fixed_weight_pkg::xof_in_len_word);
            send_seed(s > 0);
            while (!done) @(negedge clk);
            if (!vector_valid) begin
                fail_run("vector_valid not raised with done");
            end
            check_count(absorb_exp.size(), 0, "absorb words left over");
            attempts = sq_words.size() / fixed_weight_pkg::squeeze_words;
            k = 0;
            ok = 1'b0;
            while (!ok && k < attempts) begin
                model_attempt(k, ok);
                k++;
            end
            if (!ok) begin
                fail_run("done raised although no recorded attempt succeeds");
            end
            check_count(sq_words.size(), k * fixed_weight_pkg::squeeze_words,
                        "squeeze words consumed");
            ones = 0;
            for (int a = 0; a < fixed_weight_pkg::vec_words; a++) begin
                rd_req.en = 1'b1;
                rd_req.addr = fixed_weight_pkg::vec_addr_t'(a);
                @(negedge clk);
                rd_req.en = 1'b0;
                rd_vec[a] = rd_data;
                ones += $countones(rd_data);
            end
            check_loc(fixed_weight_pkg::loc_t'(ones),
                      fixed_weight_pkg::loc_t'(fixed_weight_pkg::weight), "vector weight");
            for (int a = 0; a < fixed_weight_pkg::vec_words; a++) begin
                check_word(rd_vec[a], exp_vec[a], "vector word");
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule
